// File: hw/cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    typedef enum logic [`CPU_OPCODE_W-1:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addi  = 6'h08,
        op_andi  = 6'h0C,
        op_ori   = 6'h0D,
        op_sw    = 6'h2B,
        op_halt  = 6'h3F
    } opcode_e;

    typedef enum logic [`CPU_FUNCT_W-1:0] {
        fn_sll = 6'h00,
        fn_srl = 6'h02,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_xor = 6'h26,
        fn_slt = 6'h2A
    } funct_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_srl
    } alu_op_e;

    // operand source, most recent producer first
    typedef enum logic [1:0] {
        fwd_none,
        fwd_exec,
        fwd_wb
    } fwd_sel_e;

    typedef enum logic [1:0] {
        br_none,
        br_eq,
        br_ne,
        br_jump
    } branch_kind_e;

    typedef struct packed {
        logic                 valid;
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] instr;
    } fetch_t;

    typedef struct packed {
        logic                       valid;
        alu_op_e                    alu_op;
        branch_kind_e               branch_kind;
        logic                       reg_write;
        logic                       is_store;
        logic                       is_halt;
        logic [`CPU_REG_ADDR_W-1:0] rs_idx;
        logic [`CPU_REG_ADDR_W-1:0] rt_idx;
        logic [`CPU_REG_ADDR_W-1:0] dest_idx;
        logic [`CPU_XLEN-1:0]       rs_val;
        logic [`CPU_XLEN-1:0]       rt_val;
        logic [`CPU_XLEN-1:0]       imm;
        logic [`CPU_SHAMT_W-1:0]    shamt;
        logic                       use_imm;
        logic [`CPU_XLEN-1:0]       pc;
        logic [`CPU_XLEN-1:0]       jump_target;
    } decoded_t;

    typedef struct packed {
        logic                       valid;
        logic                       reg_write;
        logic                       is_store;
        logic                       is_halt;
        logic [`CPU_REG_ADDR_W-1:0] dest_idx;
        logic [`CPU_XLEN-1:0]       result;
        logic [`CPU_XLEN-1:0]       store_data;
    } exec_result_t;

    typedef struct packed {
        logic                       valid;
        logic                       reg_write;
        logic [`CPU_REG_ADDR_W-1:0] dest_idx;
        logic [`CPU_XLEN-1:0]       data;
    } writeback_t;

endpackage

// File: hw/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and instruction word
`define CPU_XLEN         32

// register file
`define CPU_REG_ADDR_W   5
`define CPU_REG_COUNT    (1 << `CPU_REG_ADDR_W)

// instruction memory, word addressed
`define CPU_IMEM_ADDR_W  8
`define CPU_IMEM_DEPTH   (1 << `CPU_IMEM_ADDR_W)

// instruction fields
`define CPU_OPCODE_W     6
`define CPU_FUNCT_W      6
`define CPU_SHAMT_W      5
`define CPU_IMM_W        16

// j carries a word index below the opcode
`define CPU_JIDX_W       (`CPU_XLEN - `CPU_OPCODE_W)

// rs, rt, rd sit right below the opcode
`define CPU_RS_LSB       (`CPU_XLEN - `CPU_OPCODE_W - `CPU_REG_ADDR_W)
`define CPU_RT_LSB       (`CPU_RS_LSB - `CPU_REG_ADDR_W)
`define CPU_RD_LSB       (`CPU_RT_LSB - `CPU_REG_ADDR_W)

`endif

// File: hw/decode_stage.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module decode_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                run,
    input  cpu_pkg::fetch_t     fetch,
    input  logic                redirect,
    input  cpu_pkg::writeback_t wb,
    output cpu_pkg::decoded_t   decoded
);

    logic [`CPU_XLEN-1:0]       regs [`CPU_REG_COUNT];
    cpu_pkg::opcode_e           opcode;
    cpu_pkg::funct_e            funct;
    logic [`CPU_REG_ADDR_W-1:0] rs;
    logic [`CPU_REG_ADDR_W-1:0] rt;
    logic [`CPU_REG_ADDR_W-1:0] rd;
    logic [`CPU_IMM_W-1:0]      imm16;
    logic [`CPU_XLEN-1:0]       rs_val;
    logic [`CPU_XLEN-1:0]       rt_val;
    logic                       wr_en;
    logic                       known;
    cpu_pkg::decoded_t          next;

    assign opcode = cpu_pkg::opcode_e'(fetch.instr[`CPU_XLEN-1 -: `CPU_OPCODE_W]);
    assign funct  = cpu_pkg::funct_e'(fetch.instr[`CPU_FUNCT_W-1:0]);
    assign rs     = fetch.instr[`CPU_RS_LSB +: `CPU_REG_ADDR_W];
    assign rt     = fetch.instr[`CPU_RT_LSB +: `CPU_REG_ADDR_W];
    assign rd     = fetch.instr[`CPU_RD_LSB +: `CPU_REG_ADDR_W];
    assign imm16  = fetch.instr[`CPU_IMM_W-1:0];

    // r0 is never written
    assign wr_en = wb.valid && wb.reg_write && (wb.dest_idx != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wb.dest_idx] <= wb.data;
        end
    end

    // write-through covers the instruction three ahead
    assign rs_val = (rs == '0) ? '0 : (wr_en && wb.dest_idx == rs) ? wb.data : regs[rs];
    assign rt_val = (rt == '0) ? '0 : (wr_en && wb.dest_idx == rt) ? wb.data : regs[rt];

    always_comb begin
        next             = '0;
        known            = 1'b1;
        next.valid       = fetch.valid;
        next.rs_idx      = rs;
        next.rt_idx      = rt;
        next.dest_idx    = rd;
        next.rs_val      = rs_val;
        next.rt_val      = rt_val;
        next.imm         = {{(`CPU_XLEN-`CPU_IMM_W){imm16[`CPU_IMM_W-1]}}, imm16};
        next.shamt       = fetch.instr[`CPU_FUNCT_W +: `CPU_SHAMT_W];
        next.pc          = fetch.pc;
        next.jump_target = `CPU_XLEN'({fetch.instr[`CPU_JIDX_W-1:0], 2'b00});
        next.alu_op      = cpu_pkg::alu_add;
        next.branch_kind = cpu_pkg::br_none;
        case (opcode)
            cpu_pkg::op_rtype: begin
                next.reg_write = 1'b1;
                case (funct)
                    cpu_pkg::fn_sll: next.alu_op = cpu_pkg::alu_sll;
                    cpu_pkg::fn_srl: next.alu_op = cpu_pkg::alu_srl;
                    cpu_pkg::fn_add: next.alu_op = cpu_pkg::alu_add;
                    cpu_pkg::fn_sub: next.alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::fn_and: next.alu_op = cpu_pkg::alu_and;
                    cpu_pkg::fn_or:  next.alu_op = cpu_pkg::alu_or;
                    cpu_pkg::fn_xor: next.alu_op = cpu_pkg::alu_xor;
                    cpu_pkg::fn_slt: next.alu_op = cpu_pkg::alu_slt;
                    default:         known = 1'b0;
                endcase
            end
            cpu_pkg::op_j:   next.branch_kind = cpu_pkg::br_jump;
            cpu_pkg::op_beq: next.branch_kind = cpu_pkg::br_eq;
            cpu_pkg::op_bne: next.branch_kind = cpu_pkg::br_ne;
            cpu_pkg::op_addi: begin
                next.reg_write = 1'b1;
                next.use_imm   = 1'b1;
                next.dest_idx  = rt;
            end
            cpu_pkg::op_andi, cpu_pkg::op_ori: begin
                next.reg_write = 1'b1;
                next.use_imm   = 1'b1;
                next.dest_idx  = rt;
                // logic immediates are zero extended
                next.imm       = `CPU_XLEN'(imm16);
                next.alu_op    = (opcode == cpu_pkg::op_andi) ? cpu_pkg::alu_and
                                                              : cpu_pkg::alu_or;
            end
            // address = rs + imm, data = rt
            cpu_pkg::op_sw: begin
                next.is_store = 1'b1;
                next.use_imm  = 1'b1;
            end
            cpu_pkg::op_halt: next.is_halt = 1'b1;
            default:          known = 1'b0;
        endcase
        if (!known) begin
            next.valid = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            decoded <= '0;
        end else begin
            decoded       <= next;
            decoded.valid <= next.valid && run && !redirect;
        end
    end

    unknown_instr: assert property (@(posedge clk) disable iff (!arst_n)
        fetch.valid && run && !redirect |-> known)
        else $error("unknown instruction %h at pc %h", fetch.instr, fetch.pc);

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module execute_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   run,
    input  cpu_pkg::decoded_t      decoded,
    input  cpu_pkg::writeback_t    wb,
    output cpu_pkg::exec_result_t  exec,
    output logic                   redirect,
    output logic [`CPU_XLEN-1:0]   redirect_pc
);

    cpu_pkg::fwd_sel_e    rs_sel;
    cpu_pkg::fwd_sel_e    rt_sel;
    logic [`CPU_XLEN-1:0] rs_op;
    logic [`CPU_XLEN-1:0] rt_op;
    logic [`CPU_XLEN-1:0] op_b;
    logic [`CPU_XLEN-1:0] alu_out;
    logic [`CPU_XLEN-1:0] branch_target;
    logic                 taken;

    // one older sits in exec, two older in wb
    function automatic cpu_pkg::fwd_sel_e pick(
        input logic [`CPU_REG_ADDR_W-1:0] idx,
        input cpu_pkg::exec_result_t      ex,
        input cpu_pkg::writeback_t        w
    );
        if (idx == '0) begin
            return cpu_pkg::fwd_none;
        end
        if (ex.valid && ex.reg_write && ex.dest_idx == idx) begin
            return cpu_pkg::fwd_exec;
        end
        if (w.valid && w.reg_write && w.dest_idx == idx) begin
            return cpu_pkg::fwd_wb;
        end
        return cpu_pkg::fwd_none;
    endfunction

    function automatic logic [`CPU_XLEN-1:0] operand(
        input cpu_pkg::fwd_sel_e    sel,
        input logic [`CPU_XLEN-1:0] reg_val,
        input logic [`CPU_XLEN-1:0] ex_val,
        input logic [`CPU_XLEN-1:0] wb_val
    );
        case (sel)
            cpu_pkg::fwd_exec: return ex_val;
            cpu_pkg::fwd_wb:   return wb_val;
            default:           return reg_val;
        endcase
    endfunction

    assign rs_sel = pick(decoded.rs_idx, exec, wb);
    assign rt_sel = pick(decoded.rt_idx, exec, wb);
    assign rs_op  = operand(rs_sel, decoded.rs_val, exec.result, wb.data);
    assign rt_op  = operand(rt_sel, decoded.rt_val, exec.result, wb.data);
    assign op_b   = decoded.use_imm ? decoded.imm : rt_op;

    always_comb begin
        case (decoded.alu_op)
            cpu_pkg::alu_add: alu_out = rs_op + op_b;
            cpu_pkg::alu_sub: alu_out = rs_op - op_b;
            cpu_pkg::alu_and: alu_out = rs_op & op_b;
            cpu_pkg::alu_or:  alu_out = rs_op | op_b;
            cpu_pkg::alu_xor: alu_out = rs_op ^ op_b;
            cpu_pkg::alu_slt: alu_out = `CPU_XLEN'($signed(rs_op) < $signed(op_b));
            // shifts take rt, amount from shamt
            cpu_pkg::alu_sll: alu_out = rt_op << decoded.shamt;
            cpu_pkg::alu_srl: alu_out = rt_op >> decoded.shamt;
            default:          alu_out = '0;
        endcase
    end

    assign branch_target = decoded.pc + `CPU_XLEN'(4) + {decoded.imm[`CPU_XLEN-3:0], 2'b00};

    always_comb begin
        case (decoded.branch_kind)
            cpu_pkg::br_eq:   taken = (rs_op == rt_op);
            cpu_pkg::br_ne:   taken = (rs_op != rt_op);
            cpu_pkg::br_jump: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    assign redirect    = decoded.valid && taken;
    assign redirect_pc = (decoded.branch_kind == cpu_pkg::br_jump) ? decoded.jump_target
                                                                  : branch_target;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exec <= '0;
        end else begin
            exec.valid      <= decoded.valid && run;
            exec.reg_write  <= decoded.reg_write;
            exec.is_store   <= decoded.is_store;
            exec.is_halt    <= decoded.is_halt;
            exec.dest_idx   <= decoded.dest_idx;
            exec.result     <= alu_out;
            exec.store_data <= rt_op;
        end
    end

    // the slot decode fills right after a redirect is a flushed one
    redirect_flush: assert property (@(posedge clk) disable iff (!arst_n)
        redirect |=> !decoded.valid)
        else $error("decode slot after a redirect was not flushed");

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module fetch_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        run,
    input  logic                        load_en,
    input  logic [`CPU_IMEM_ADDR_W-1:0] load_addr,
    input  logic [`CPU_XLEN-1:0]        load_data,
    input  logic                        redirect,
    input  logic [`CPU_XLEN-1:0]        redirect_pc,
    input  logic                        halted,
    output cpu_pkg::fetch_t             fetch
);

    logic [`CPU_XLEN-1:0]        imem [`CPU_IMEM_DEPTH];
    logic [`CPU_XLEN-1:0]        pc;
    logic [`CPU_IMEM_ADDR_W-1:0] rd_addr;

    // byte pc to word index
    assign rd_addr = pc[`CPU_IMEM_ADDR_W+1:2];

    // loader port, only while stopped
    always_ff @(posedge clk) begin
        if (load_en && !run) begin
            imem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc    <= '0;
            fetch <= '0;
        end else if (!run) begin
            pc    <= '0;
            fetch <= '0;
        end else if (halted) begin
            fetch.valid <= 1'b0;
        end else begin
            // word read this cycle is the one after the branch, so drop it
            fetch.valid <= !redirect;
            fetch.pc    <= pc;
            fetch.instr <= imem[rd_addr];
            pc          <= redirect ? redirect_pc : pc + `CPU_XLEN'(4);
        end
    end

    load_while_stopped: assert property (@(posedge clk) disable iff (!arst_n)
        load_en |-> !run)
        else $error("instruction load while the core is running");

    // targets come from execute, so this covers the redirect math too
    pc_word_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00)
        else $error("pc %h not word aligned", pc);

endmodule

// File: hw/mips_pipe_top.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module mips_pipe_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        run,
    input  logic                        load_en,
    input  logic [`CPU_IMEM_ADDR_W-1:0] load_addr,
    input  logic [`CPU_XLEN-1:0]        load_data,
    output logic                        store_valid,
    output logic [`CPU_XLEN-1:0]        store_addr,
    output logic [`CPU_XLEN-1:0]        store_data,
    output logic                        halted
);

    cpu_pkg::fetch_t       fetch;
    cpu_pkg::decoded_t     decoded;
    cpu_pkg::exec_result_t exec;
    cpu_pkg::writeback_t   wb;
    logic                  redirect;
    logic [`CPU_XLEN-1:0]  redirect_pc;

    fetch_stage i_fetch_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .halted      (halted),
        .fetch       (fetch)
    );

    decode_stage i_decode_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .fetch       (fetch),
        .redirect    (redirect),
        .wb          (wb),
        .decoded     (decoded)
    );

    // exec also feeds back into its own forwarding mux
    execute_stage i_execute_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .decoded     (decoded),
        .wb          (wb),
        .exec        (exec),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    result_stage i_result_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .exec        (exec),
        .wb          (wb),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .halted      (halted)
    );

endmodule

// File: hw/result_stage.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module result_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  run,
    input  cpu_pkg::exec_result_t exec,
    output cpu_pkg::writeback_t   wb,
    output logic                  store_valid,
    output logic [`CPU_XLEN-1:0]  store_addr,
    output logic [`CPU_XLEN-1:0]  store_data,
    output logic                  halted
);

    logic live;

    // nothing younger than the halt retires
    assign live = exec.valid && run && !halted;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb          <= '0;
            store_valid <= 1'b0;
            halted      <= 1'b0;
        end else begin
            wb.valid     <= live;
            wb.reg_write <= exec.reg_write;
            wb.dest_idx  <= exec.dest_idx;
            wb.data      <= exec.result;
            store_valid  <= live && exec.is_store;
            if (!run) begin
                halted <= 1'b0;
            end else if (live && exec.is_halt) begin
                halted <= 1'b1;
            end
        end
    end

    // address and data hold after the pulse
    always_ff @(posedge clk) begin
        if (live && exec.is_store) begin
            store_addr <= exec.result;
            store_data <= exec.store_data;
        end
    end

    no_store_after_halt: assert property (@(posedge clk) disable iff (!arst_n)
        !(store_valid && halted))
        else $error("store issued while halted");

endmodule

// File: mips_pipe.f
+incdir+hw
+incdir+verification
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/mips_pipe_top.sv
verification/mips_pipe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the pipeline testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module mips_pipe_tb \
    -f mips_pipe.f \
    -o sim_mips_pipe

./obj_dir/sim_mips_pipe | tee sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi

// File: verification/mips_pipe_programs.svh
`ifndef MIPS_PIPE_PROGRAMS_SVH
`define MIPS_PIPE_PROGRAMS_SVH

// one row per program: name, words loaded from address 0, stores in program order
localparam int NUM_PROGS = 5;

string                prog_name   [NUM_PROGS];
int                   prog_len    [NUM_PROGS];
logic [`CPU_XLEN-1:0] prog_words  [NUM_PROGS][MAX_WORDS];
int                   store_count [NUM_PROGS];
store_t               exp_stores  [NUM_PROGS][MAX_STORES];

task automatic push_word(input int p, input logic [`CPU_XLEN-1:0] w);
    prog_words[p][prog_len[p]] = w;
    prog_len[p]++;
endtask

task automatic record_store(input int p, input logic [`CPU_XLEN-1:0] addr,
                            input logic [`CPU_XLEN-1:0] data);
    exp_stores[p][store_count[p]].addr = addr;
    exp_stores[p][store_count[p]].data = data;
    store_count[p]++;
endtask

task automatic build_table;
    for (int p = 0; p < NUM_PROGS; p++) begin
        prog_len[p]    = 0;
        store_count[p] = 0;
    end

    // distance 1, 2 and 3 producers, then store data and address forwarding
    prog_name[0] = "dependent_chain";
    push_word(0, itype(cpu_pkg::op_addi, 1, 0, 16'h0005));
    push_word(0, itype(cpu_pkg::op_addi, 2, 0, 16'h0013));
    push_word(0, rtype(cpu_pkg::fn_add, 3, 1, 2));
    push_word(0, rtype(cpu_pkg::fn_sub, 4, 3, 1));
    push_word(0, rtype(cpu_pkg::fn_and, 5, 4, 3));
    push_word(0, rtype(cpu_pkg::fn_or, 6, 5, 1));
    push_word(0, rtype(cpu_pkg::fn_xor, 7, 6, 4));
    push_word(0, itype(cpu_pkg::op_addi, 8, 0, 16'h0100));
    push_word(0, itype(cpu_pkg::op_sw, 7, 8, 16'h0004));
    push_word(0, itype(cpu_pkg::op_sw, 6, 8, 16'h0008));
    push_word(0, itype(cpu_pkg::op_sw, 5, 8, 16'h000C));
    push_word(0, itype(cpu_pkg::op_sw, 4, 8, 16'h0010));
    push_word(0, itype(cpu_pkg::op_sw, 3, 8, 16'h0014));
    push_word(0, halt_word(0));
    record_store(0, 32'h0000_0104, 32'h0000_0006);
    record_store(0, 32'h0000_0108, 32'h0000_0015);
    record_store(0, 32'h0000_010C, 32'h0000_0010);
    record_store(0, 32'h0000_0110, 32'h0000_0013);
    record_store(0, 32'h0000_0114, 32'h0000_0018);

    prog_name[1] = "imm_shift_slt";
    push_word(1, itype(cpu_pkg::op_addi, 1, 0, 16'hFFFC));
    push_word(1, itype(cpu_pkg::op_ori, 2, 0, 16'h8001));
    push_word(1, itype(cpu_pkg::op_andi, 3, 1, 16'hF0F0));
    push_word(1, rtype(cpu_pkg::fn_sll, 4, 0, 2, 4));
    push_word(1, rtype(cpu_pkg::fn_srl, 5, 0, 1, 8));
    push_word(1, rtype(cpu_pkg::fn_slt, 6, 1, 2));
    push_word(1, rtype(cpu_pkg::fn_slt, 7, 2, 1));
    push_word(1, itype(cpu_pkg::op_sw, 1, 0, 16'h0040));
    push_word(1, itype(cpu_pkg::op_sw, 2, 0, 16'h0044));
    push_word(1, itype(cpu_pkg::op_sw, 3, 0, 16'h0048));
    push_word(1, itype(cpu_pkg::op_sw, 4, 0, 16'h004C));
    push_word(1, itype(cpu_pkg::op_sw, 5, 0, 16'h0050));
    push_word(1, itype(cpu_pkg::op_sw, 6, 0, 16'h0054));
    // negative offset from r4
    push_word(1, itype(cpu_pkg::op_sw, 7, 4, 16'hFFF0));
    push_word(1, halt_word(0));
    record_store(1, 32'h0000_0040, 32'hFFFF_FFFC);
    record_store(1, 32'h0000_0044, 32'h0000_8001);
    record_store(1, 32'h0000_0048, 32'h0000_F0F0);
    record_store(1, 32'h0000_004C, 32'h0008_0010);
    record_store(1, 32'h0000_0050, 32'h00FF_FFFF);
    record_store(1, 32'h0000_0054, 32'h0000_0001);
    record_store(1, 32'h0008_0000, 32'h0000_0000);

    // taken beq skips words 3 and 4, bne falls through
    prog_name[2] = "branches";
    push_word(2, itype(cpu_pkg::op_addi, 1, 0, 16'h0007));
    push_word(2, itype(cpu_pkg::op_addi, 2, 0, 16'h0007));
    push_word(2, itype(cpu_pkg::op_beq, 2, 1, 16'h0002));
    push_word(2, itype(cpu_pkg::op_sw, 1, 0, 16'h0060));
    push_word(2, itype(cpu_pkg::op_sw, 2, 0, 16'h0064));
    push_word(2, itype(cpu_pkg::op_sw, 1, 0, 16'h0068));
    push_word(2, itype(cpu_pkg::op_addi, 3, 1, 16'h0000));
    push_word(2, itype(cpu_pkg::op_bne, 2, 3, 16'h0002));
    push_word(2, itype(cpu_pkg::op_sw, 2, 0, 16'h006C));
    push_word(2, itype(cpu_pkg::op_sw, 3, 0, 16'h0070));
    push_word(2, halt_word(0));
    record_store(2, 32'h0000_0068, 32'h0000_0007);
    record_store(2, 32'h0000_006C, 32'h0000_0007);
    record_store(2, 32'h0000_0070, 32'h0000_0007);

    prog_name[3] = "jump_halt";
    push_word(3, itype(cpu_pkg::op_addi, 1, 0, 16'h0011));
    push_word(3, jump_to(4));
    push_word(3, itype(cpu_pkg::op_sw, 1, 0, 16'h0080));
    push_word(3, itype(cpu_pkg::op_sw, 1, 0, 16'h0084));
    push_word(3, itype(cpu_pkg::op_sw, 1, 0, 16'h0088));
    push_word(3, halt_word(0));
    push_word(3, itype(cpu_pkg::op_sw, 1, 0, 16'h008C));
    push_word(3, itype(cpu_pkg::op_sw, 1, 0, 16'h0090));
    push_word(3, itype(cpu_pkg::op_sw, 1, 0, 16'h0094));
    record_store(3, 32'h0000_0088, 32'h0000_0011);

    // shorter than the last one, its old stores sit past the halt
    prog_name[4] = "reload";
    push_word(4, itype(cpu_pkg::op_addi, 9, 0, 16'h0003));
    push_word(4, rtype(cpu_pkg::fn_sll, 9, 0, 9, 2));
    push_word(4, itype(cpu_pkg::op_sw, 9, 0, 16'h00A0));
    push_word(4, halt_word(0));
    record_store(4, 32'h0000_00A0, 32'h0000_000C);
endtask

`endif

// File: verification/mips_pipe_tb.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module mips_pipe_tb;

    localparam int MAX_WORDS     = 16;
    localparam int MAX_STORES    = 8;
    localparam int STORE_TIMEOUT = 200;
    localparam int HALT_WATCH    = 10;
    localparam int CLEAR_TIMEOUT = 4;
    localparam int JIDX_W        = `CPU_JIDX_W;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] addr;
        logic [`CPU_XLEN-1:0] data;
    } store_t;

    logic                        clk;
    logic                        arst_n;
    logic                        run;
    logic                        load_en;
    logic [`CPU_IMEM_ADDR_W-1:0] load_addr;
    logic [`CPU_XLEN-1:0]        load_data;
    logic                        store_valid;
    logic [`CPU_XLEN-1:0]        store_addr;
    logic [`CPU_XLEN-1:0]        store_data;
    logic                        halted;

    int     errors;
    int     passed;
    int     failed;
    store_t seen [$];

    mips_pipe_top i_mips_pipe_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .halted      (halted)
    );

    always #50 clk = ~clk;

    // instruction encoders
    function automatic logic [`CPU_XLEN-1:0] rtype(input cpu_pkg::funct_e fn, input int rd,
                                                   input int rs, input int rt,
                                                   input int shamt = 0);
        return {cpu_pkg::op_rtype, `CPU_REG_ADDR_W'(rs), `CPU_REG_ADDR_W'(rt),
                `CPU_REG_ADDR_W'(rd), `CPU_SHAMT_W'(shamt), fn};
    endfunction

    function automatic logic [`CPU_XLEN-1:0] itype(input cpu_pkg::opcode_e op, input int rt,
                                                   input int rs, input int imm);
        return {op, `CPU_REG_ADDR_W'(rs), `CPU_REG_ADDR_W'(rt), `CPU_IMM_W'(imm)};
    endfunction

    function automatic logic [`CPU_XLEN-1:0] jump_to(input int word_idx);
        return {cpu_pkg::op_j, JIDX_W'(word_idx)};
    endfunction

    // low bits are free, so the fill can tag each word with its address
    function automatic logic [`CPU_XLEN-1:0] halt_word(input int tag);
        return {cpu_pkg::op_halt, JIDX_W'(tag)};
    endfunction

    `include "mips_pipe_programs.svh"

    task automatic compare_store(input int idx, input store_t got, input store_t exp);
        if (got.addr !== exp.addr) begin
            $display("ERROR store_addr (store %0d): got %h expected %h", idx, got.addr, exp.addr);
            errors++;
        end
        if (got.data !== exp.data) begin
            $display("ERROR store_data (store %0d): got %h expected %h", idx, got.data, exp.data);
            errors++;
        end
    endtask

    task automatic verify_status(input int got_count, input int exp_count,
                                 input logic got_halted, input logic exp_halted);
        if (got_count != exp_count) begin
            $display("wrong number of stores: saw %0d, wanted %0d", got_count, exp_count);
            errors++;
        end
        if (got_halted !== exp_halted) begin
            $display("ERROR halted: got %h expected %h", got_halted, exp_halted);
            errors++;
        end
    endtask

    task automatic log_result(input string name, input int start_err, input int n_stores);
        if (errors == start_err) begin
            passed++;
            $display("pass  %-16s %0d stores", name, n_stores);
        end else begin
            failed++;
            $display("FAIL  %-16s %0d stores, %0d errors", name, n_stores, errors - start_err);
        end
    endtask

    task automatic load_word(input int addr, input logic [`CPU_XLEN-1:0] word);
        @(negedge clk);
        load_en   = 1'b1;
        load_addr = `CPU_IMEM_ADDR_W'(addr);
        load_data = word;
    endtask

    task automatic fill_imem;
        for (int a = 0; a < `CPU_IMEM_DEPTH; a++) begin
            load_word(a, halt_word(a));
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic idle_after_reset;
        int   pulses;
        int   start_err;
        logic any_halt;
        start_err = errors;
        // reset values, before the first clock edge can mask them
        pulses    = (store_valid !== 1'b0) ? 1 : 0;
        any_halt  = halted;
        repeat (8) begin
            @(negedge clk);
            if (store_valid) begin
                pulses++;
            end
            any_halt = any_halt | halted;
        end
        verify_status(pulses, 0, any_halt, 1'b0);
        log_result("reset_idle", start_err, pulses);
    endtask

    task automatic run_program(input int p);
        int     start_err;
        int     cycles;
        store_t s;
        start_err = errors;
        seen.delete();
        @(negedge clk);
        run    = 1'b0;
        cycles = 0;
        while (halted && cycles < CLEAR_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (halted) begin
            $display("halted stayed high after run was dropped");
            errors++;
        end
        for (int i = 0; i < prog_len[p]; i++) begin
            load_word(i, prog_words[p][i]);
        end
        @(negedge clk);
        load_en = 1'b0;
        run     = 1'b1;
        cycles  = 0;
        while (!halted && cycles < STORE_TIMEOUT) begin
            @(negedge clk);
            if (store_valid) begin
                s.addr = store_addr;
                s.data = store_data;
                seen.push_back(s);
            end
            cycles++;
        end
        if (!halted) begin
            $display("timeout: core did not halt within %0d cycles", STORE_TIMEOUT);
            errors++;
        end
        // anything after the halt counts as an extra store
        repeat (HALT_WATCH) begin
            @(negedge clk);
            if (store_valid) begin
                s.addr = store_addr;
                s.data = store_data;
                seen.push_back(s);
            end
        end
        for (int i = 0; i < seen.size() && i < store_count[p]; i++) begin
            compare_store(i, seen[i], exp_stores[p][i]);
        end
        verify_status(seen.size(), store_count[p], halted, 1'b1);
        log_result(prog_name[p], start_err, seen.size());
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        build_table();
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        idle_after_reset();
        fill_imem();
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_program(p);
        end
        $display("%0d tests passed, %0d tests failed, %0d errors", passed, failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
